// ==== build.f ====
rtl/conv_cfg_pkg.sv
rtl/conv_if_pkg.sv
rtl/conv_window_buffer.sv
rtl/conv_weight_rom.sv
rtl/conv_node.sv
rtl/conv_layer.sv
rtl/conv_merge.sv
rtl/conv_pair_top.sv
dv/conv_properties.sv
dv/conv_checker.sv
dv/conv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the convolution tile testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module conv_tb -o conv_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/conv_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation stopped with an error"; exit 1; }

cat sim.log

grep -q "Test failed" sim.log \
    && { echo "Simulation reported a failure"; exit 1; }

echo "Simulation finished without failures"
exit 0

// ==== dv/conv_tb.sv ====
// Testbench of the two-channel convolution tile with credit models on both sides
`timescale 1ns/100ps

module conv_tb;
    import conv_cfg_pkg::*;
    import conv_if_pkg::*;

    localparam int NUM_TESTS = 10;
    localparam int TIMEOUT   = 500;

    typedef struct packed {
        window_t    win;
        logic [7:0] idle;   // Cycles before the window is sent
        logic [7:0] delay;  // Cycles downstream holds the credit of this result
    } stim_t;

    logic    clk_i = 1'b0;
    logic    reset_i;
    logic    win_valid;
    window_t win;
    logic    tile_credit;
    logic    down_credit;
    logic    result_valid;
    result_t result;
    logic    check_end;
    logic    timed_out = 1'b0;
    integer  seed = 32'hd566fb8c;
    stim_t   stim_tab [NUM_TESTS];
    int      due_q [$];     // Cycles at which downstream frees its held results
    int      sent     = 0;
    int      returned = 0;
    int      cycle    = 0;
    int      res_seen = 0;
    int      waited;
    int      errors;
    int      passes;
    int      results;

    always #50 clk_i = ~clk_i;

    conv_pair_top i_conv_pair_top (
        .clk_i,
        .reset_i,
        .win_valid_i    (win_valid),
        .win_i          (win),
        .credit_o       (tile_credit),
        .credit_i       (down_credit),
        .result_valid_o (result_valid),
        .result_o       (result)
    );

    conv_checker i_checker (
        .clk_i,
        .reset_i,
        .win_valid_i    (win_valid),
        .win_i          (win),
        .tile_credit_i  (tile_credit),
        .down_credit_i  (down_credit),
        .result_valid_i (result_valid),
        .result_i       (result),
        .check_end_i    (check_end),
        .error_count_o  (errors),
        .pass_count_o   (passes),
        .result_count_o (results)
    );

    bind conv_pair_top conv_properties i_conv_properties (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .win_valid_i    (win_valid_i),
        .pop_i          (pop),
        .tile_credit_i  (credit_o),
        .down_credit_i  (credit_i),
        .result_valid_i (result_valid_o)
    );

    function automatic window_t constant_window(word_t value);
        window_t w;
        for (int r = 0; r < INPUT_HEIGHT; r++) begin
            for (int c = 0; c < KERNEL_WIDTH; c++) begin
                w.pixels[r][c] = value;
            end
        end
        return w;
    endfunction

    function automatic window_t ramp_window(int scale, int offset);
        window_t w;
        for (int r = 0; r < INPUT_HEIGHT; r++) begin
            for (int c = 0; c < KERNEL_WIDTH; c++) begin
                w.pixels[r][c] = word_t'((r * KERNEL_WIDTH + c) * scale + offset);
            end
        end
        return w;
    endfunction

    // Small signed pixels so that most rows stay inside the word range
    function automatic window_t random_window();
        window_t w;
        for (int r = 0; r < INPUT_HEIGHT; r++) begin
            for (int c = 0; c < KERNEL_WIDTH; c++) begin
                w.pixels[r][c] = word_t'($random(seed) % 200);
            end
        end
        return w;
    endfunction

    // One more cycle of a wait, or the end of it once it has run too long
    task automatic wait_cycle(input string what, inout int count);
        if (count >= TIMEOUT) begin
            $display("ERROR: timeout after %0d cycles while %s", count, what);
            timed_out = 1'b1;
        end else begin
            @(posedge clk_i);
            #1;
            count++;
        end
    endtask

    // Downstream frees each result after its table delay and counts input credits
    always begin
        @(posedge clk_i);
        cycle++;
        if (!reset_i && result_valid) begin
            due_q.push_back(cycle + ((res_seen < NUM_TESTS) ? int'(stim_tab[res_seen].delay) : 0));
            res_seen++;
        end
        if (!reset_i && tile_credit) begin
            returned++;
        end
        #1;
        down_credit = (due_q.size() > 0) && (due_q[0] <= cycle);
        if (down_credit) begin
            void'(due_q.pop_front());
        end
    end

    initial begin
        reset_i     = 1'b1;
        win_valid   = 1'b0;
        win         = '0;
        down_credit = 1'b0;
        check_end   = 1'b0;
        stim_tab[0] = '{random_window(), 8'd5, 8'd0};
        stim_tab[1] = '{ramp_window(1, 1), 8'd0, 8'd1};
        stim_tab[2] = '{random_window(), 8'd0, 8'd0};
        stim_tab[3] = '{constant_window(-16'sd1000), 8'd2, 8'd30};  // Negative sums
        stim_tab[4] = '{random_window(), 8'd0, 8'd30};
        stim_tab[5] = '{constant_window(WORD_MAX), 8'd0, 8'd0};     // Saturating rows
        stim_tab[6] = '{random_window(), 8'd1, 8'd3};
        stim_tab[7] = '{constant_window(16'sd0), 8'd0, 8'd40};      // Biases only
        stim_tab[8] = '{random_window(), 8'd0, 8'd0};
        stim_tab[9] = '{ramp_window(-23, 60), 8'd3, 8'd2};
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        for (int k = 0; (k < NUM_TESTS) && !timed_out; k++) begin
            repeat (int'(stim_tab[k].idle)) begin
                @(posedge clk_i);
                #1;
            end
            waited = 0;
            while (!timed_out && (int'(IN_CREDITS) - sent + returned <= 0)) begin
                wait_cycle("waiting for an input credit", waited);
            end
            if (!timed_out) begin
                win_valid = 1'b1;
                win       = stim_tab[k].win;
                sent++;
                @(posedge clk_i);
                #1;
                win_valid = 1'b0;
            end
        end
        waited = 0;
        while (!timed_out && (results < NUM_TESTS)) begin
            wait_cycle("waiting for the remaining results", waited);
        end
        check_end = 1'b1;
        repeat (2) begin
            @(posedge clk_i);
            #1;
        end
        $display("%0d of %0d tests passed, %0d errors", passes, NUM_TESTS, errors);
        if (!timed_out && (errors == 0) && (passes == NUM_TESTS)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/conv_checker.sv ====
// Reference model of the tile that compares every result in order and watches both credit loops
`timescale 1ns/100ps

module conv_checker (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 win_valid_i,
    input  conv_if_pkg::window_t win_i,
    input  logic                 tile_credit_i,   // credit_o of the DUT
    input  logic                 down_credit_i,   // credit_i of the DUT
    input  logic                 result_valid_i,
    input  conv_if_pkg::result_t result_i,
    input  logic                 check_end_i,
    output int                   error_count_o,
    output int                   pass_count_o,
    output int                   result_count_o
);
    import conv_cfg_pkg::*;
    import conv_if_pkg::*;

    result_t expect_q [$];  // Expected rows in input order
    int      errors       = 0;
    int      passes       = 0;
    int      results      = 0;
    int      windows      = 0;
    int      tile_credits = 0;
    int      down_credits = 0;
    logic    end_checked  = 1'b0;

    // Per channel the kernel products plus bias, then both channels added with ReLU and clipping
    function automatic result_t expected_result(window_t w);
        result_t res;
        longint  total;
        longint  chan;
        word_t   px;
        word_t   wt;
        for (int r = 0; r < OUT_ROWS; r++) begin
            total = 0;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                wt   = CONV_WEIGHTS[ch][NUM_STEPS-1];
                chan = longint'(wt);  // Bias of the channel
                for (int k = 0; k < KERNEL_HEIGHT * KERNEL_WIDTH; k++) begin
                    px   = w.pixels[r + k / KERNEL_WIDTH][k % KERNEL_WIDTH];
                    wt   = CONV_WEIGHTS[ch][k];
                    chan = chan + longint'(px) * longint'(wt);
                end
                total = total + chan;
            end
            if (total < 0) begin
                res.rows[r] = '0;
            end else if (total > longint'(WORD_MAX)) begin
                res.rows[r] = WORD_MAX;
            end else begin
                res.rows[r] = word_t'(total);
            end
        end
        return res;
    endfunction

    task automatic check_result();
        result_t exp;
        if (results - down_credits >= int'(OUT_CREDITS)) begin
            errors++;
            $display("ERROR: result %0d was sent with no output credit left", results);
        end
        if (expect_q.size() == 0) begin
            errors++;
            $display("ERROR: result %0d arrived with no window left to match it", results);
        end else begin
            exp = expect_q.pop_front();
            if (result_i == exp) begin
                passes++;
                $display("test %0d passed: result_o %h", results, result_i);
            end else begin
                errors++;
                $display("FAILED test %0d: result_o expected %h, got %h", results, exp, result_i);
            end
        end
        results++;
    endtask

    always @(posedge clk_i) begin
        if (!reset_i) begin
            if ((windows == 0) && (tile_credit_i || result_valid_i)) begin
                errors++;
                $display("ERROR: credit_o or result_valid_o went high before the first window");
            end
            if (win_valid_i) begin
                if (windows - tile_credits >= int'(IN_CREDITS)) begin
                    errors++;
                    $display("ERROR: window %0d was sent with no input credit left", windows);
                end
                expect_q.push_back(expected_result(win_i));
                windows++;
            end
            if (tile_credit_i) begin
                tile_credits++;
            end
            if (result_valid_i) begin
                check_result();
            end
            if (down_credit_i) begin
                down_credits++;  // Counted after the result check, the merge sees it a cycle later
            end
            if (check_end_i && !end_checked) begin
                if (tile_credits != windows) begin
                    errors++;
                    $display("FAILED credit_o pulses: expected %h, got %h", windows, tile_credits);
                end
                if (expect_q.size() != 0) begin
                    errors++;
                    $display("ERROR: %0d results never arrived", expect_q.size());
                end
                end_checked = 1'b1;
            end
        end
    end

    assign error_count_o  = errors;
    assign pass_count_o   = passes;
    assign result_count_o = results;

endmodule

// ==== dv/conv_properties.sv ====
// Concurrent checks of the credit rules at the input and output of the convolution tile
`timescale 1ns/100ps

module conv_properties (
    input logic clk_i,
    input logic reset_i,
    input logic win_valid_i,
    input logic pop_i,
    input logic tile_credit_i,   // credit_o of the tile
    input logic down_credit_i,   // credit_i of the tile
    input logic result_valid_i
);
    import conv_if_pkg::*;

    logic [2:0] out_credits;  // Mirror of the merge's credit counter
    logic [2:0] buf_count;    // Windows held in the input FIFO

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_credits <= 3'(OUT_CREDITS);
            buf_count   <= '0;
        end else begin
            out_credits <= out_credits + 3'(down_credit_i) - 3'(result_valid_i);
            buf_count   <= buf_count + 3'(win_valid_i) - 3'(pop_i);
        end
    end

    a_result_needs_credit : assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_i |-> (out_credits != '0))
        else $error("result_valid_o is high with no output credit left");

    a_window_needs_space : assert property (@(posedge clk_i) disable iff (reset_i)
        win_valid_i |-> (buf_count < 3'(IN_CREDITS)))
        else $error("win_valid_i is high while the window buffer is full");

    // Adjacent credits need two pops, each from a FIFO that held a window
    a_credit_per_pop : assert property (@(posedge clk_i) disable iff (reset_i)
        (tile_credit_i && $past(tile_credit_i))
            |-> ($past(pop_i) && $past(pop_i, 2)
                 && ($past(buf_count) != '0) && ($past(buf_count, 2) != '0)))
        else $error("credit_o is high in two adjacent cycles without two pops");

endmodule

// ==== rtl/conv_pair_top.sv ====
// Two-channel convolution tile with credit flow control at its input and output
`timescale 1ns/100ps

module conv_pair_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 win_valid_i,
    input  conv_if_pkg::window_t win_i,
    output logic                 credit_o,
    input  logic                 credit_i,
    output logic                 result_valid_o,
    output conv_if_pkg::result_t result_o
);
    import conv_if_pkg::*;

    window_t      win;
    logic         nonempty;
    logic         pop;
    logic         done_a;
    logic         done_b;
    channel_out_t chan_a;
    channel_out_t chan_b;
    logic         merge_ready;

    // Both layers start on the same pop, so they also finish together
    assign pop = nonempty && done_a && done_b && merge_ready;

    conv_window_buffer i_window_buffer (
        .clk_i,
        .reset_i,
        .win_valid_i,
        .win_i,
        .pop_i      (pop),
        .win_o      (win),
        .nonempty_o (nonempty),
        .credit_o
    );

    conv_layer #(
        .CHANNEL(0)
    ) i_layer_a (
        .clk_i,
        .reset_i,
        .start_i  (pop),
        .win_i    (win),
        .done_o   (done_a),
        .result_o (chan_a)
    );

    conv_layer #(
        .CHANNEL(1)
    ) i_layer_b (
        .clk_i,
        .reset_i,
        .start_i  (pop),
        .win_i    (win),
        .done_o   (done_b),
        .result_o (chan_b)
    );

    conv_merge i_merge (
        .clk_i,
        .reset_i,
        .done_a_i (done_a),
        .done_b_i (done_b),
        .chan_a_i (chan_a),
        .chan_b_i (chan_b),
        .credit_i,
        .ready_o  (merge_ready),
        .result_valid_o,
        .result_o
    );

endmodule

// ==== rtl/conv_merge.sv ====
// Adds both channel sums per row with ReLU and saturation, then sends under output credits
`timescale 1ns/100ps

module conv_merge (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      done_a_i,
    input  logic                      done_b_i,
    input  conv_if_pkg::channel_out_t chan_a_i,
    input  conv_if_pkg::channel_out_t chan_b_i,
    input  logic                      credit_i,
    output logic                      ready_o,
    output logic                      result_valid_o,
    output conv_if_pkg::result_t      result_o
);
    import conv_cfg_pkg::*;
    import conv_if_pkg::*;

    logic        both_done;
    logic        both_done_q;  // Sums of the finished layers already taken
    logic        capture;
    logic        holding;      // A merged row waits to be sent
    credit_cnt_t credits;
    result_t     merged;

    function automatic word_t relu_sat(acc_t a, acc_t b);
        acc_t sum;
        sum = a + b;
        if (sum < 0) begin
            return '0;
        end else if (sum > acc_t'(WORD_MAX)) begin
            return WORD_MAX;
        end
        return word_t'(sum);
    endfunction

    always_comb begin
        for (int r = 0; r < OUT_ROWS; r++) begin
            merged.rows[r] = relu_sat(chan_a_i.sums[r], chan_b_i.sums[r]);
        end
    end

    assign both_done      = done_a_i && done_b_i;
    assign capture        = both_done && !both_done_q && !holding;  // Finished sums wait here
    assign ready_o        = !holding;
    assign result_valid_o = holding && (credits != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            both_done_q <= 1'b1;  // Nothing to take before the first window
            holding     <= 1'b0;
            credits     <= OUT_CREDITS;
        end else begin
            if (!both_done) begin
                both_done_q <= 1'b0;
            end else if (capture) begin
                both_done_q <= 1'b1;
            end
            if (capture) begin
                holding <= 1'b1;
            end else if (result_valid_o) begin
                holding <= 1'b0;
            end
            case ({result_valid_o, credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            result_o <= merged;
        end
    end

endmodule

// ==== rtl/conv_layer.sv ====
// One convolution channel that steps its kernel ROM across a window and biases the sums
`timescale 1ns/100ps

module conv_layer #(
    parameter int CHANNEL = 0
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      start_i,
    input  conv_if_pkg::window_t      win_i,
    output logic                      done_o,
    output conv_if_pkg::channel_out_t result_o
);
    import conv_cfg_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;
    step_t  step_cnt;      // ROM address, rests at zero while idle
    logic   issue;         // A ROM read belonging to the current window
    logic   last_step;
    step_t  step_q;        // Step and flags of the word now leaving the ROM
    logic   step_valid_q;
    logic   bias_q;
    word_t  weight;

    // Step 0 is already addressed in the start cycle
    assign issue     = ((state == ST_IDLE) && start_i) || (state == ST_BUSY);
    assign last_step = (step_cnt == step_t'(NUM_STEPS - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state    <= ST_BUSY;
                        step_cnt <= step_t'(1);
                    end
                end
                ST_BUSY: begin
                    if (last_step) begin
                        state    <= ST_IDLE;
                        step_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Line the step information up with the one-cycle ROM latency
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            step_valid_q <= 1'b0;
            step_q       <= '0;
            bias_q       <= 1'b0;
        end else begin
            step_valid_q <= issue;
            step_q       <= step_cnt;
            bias_q       <= issue && last_step;
        end
    end

    // Done once the bias step has been accumulated
    assign done_o = (state == ST_IDLE) && !step_valid_q;

    conv_weight_rom #(
        .CHANNEL(CHANNEL)
    ) i_weight_rom (
        .clk_i,
        .addr_i (step_cnt),
        .data_o (weight)
    );

    for (genvar i = 0; i < OUT_ROWS; i++) begin : g_node
        conv_node i_conv_node (
            .clk_i,
            .reset_i,
            .start_i,
            .column_i     (win_i.pixels[i +: KERNEL_HEIGHT]),  // Rows i to i + KERNEL_HEIGHT - 1
            .weight_i     (weight),
            .step_i       (step_q),
            .step_valid_i (step_valid_q),
            .add_bias_i   (bias_q),
            .sum_o        (result_o.sums[i])
        );
    end

endmodule

// ==== rtl/conv_node.sv ====
// Multiply-accumulate for one output row of a convolution channel
`timescale 1ns/100ps

module conv_node (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                start_i,
    input  conv_cfg_pkg::word_t [conv_cfg_pkg::KERNEL_HEIGHT-1:0]
                                [conv_cfg_pkg::KERNEL_WIDTH-1:0] column_i,
    input  conv_cfg_pkg::word_t weight_i,
    input  conv_cfg_pkg::step_t step_i,
    input  logic                step_valid_i,
    input  logic                add_bias_i,
    output conv_cfg_pkg::acc_t  sum_o
);
    import conv_cfg_pkg::*;

    localparam int NUM_TAPS = KERNEL_HEIGHT * KERNEL_WIDTH;

    word_t [NUM_TAPS-1:0] taps;  // Same order as the weights in the ROM
    word_t                pixel;
    acc_t                 product;
    acc_t                 acc;

    assign taps = column_i;

    always_comb begin
        pixel = '0;
        if (!add_bias_i && (step_i < step_t'(NUM_TAPS))) begin
            pixel = taps[step_i];
        end
        product = acc_t'(pixel) * acc_t'(weight_i);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || start_i) begin
            acc <= '0;  // Each window starts from an empty sum
        end else if (step_valid_i) begin
            if (add_bias_i) begin
                acc <= acc + acc_t'(weight_i);  // On the bias step the ROM word is the bias
            end else begin
                acc <= acc + product;
            end
        end
    end

    assign sum_o = acc;

endmodule

// ==== rtl/conv_weight_rom.sv ====
// Synchronous weight table of one convolution channel, taps first and bias last
`timescale 1ns/100ps

module conv_weight_rom #(
    parameter int CHANNEL = 0
) (
    input  logic                clk_i,
    input  conv_cfg_pkg::step_t addr_i,
    output conv_cfg_pkg::word_t data_o
);
    import conv_cfg_pkg::*;

    logic addr_ok;

    // The counter never goes past the bias entry, spare codes read as zero
    assign addr_ok = (addr_i < step_t'(NUM_STEPS));

    always_ff @(posedge clk_i) begin
        if (addr_ok) begin
            data_o <= CONV_WEIGHTS[CHANNEL][addr_i];
        end else begin
            data_o <= '0;
        end
    end

endmodule

// ==== rtl/conv_window_buffer.sv ====
// Two-entry input FIFO that holds windows until both layers accept them
`timescale 1ns/100ps

module conv_window_buffer (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 win_valid_i,
    input  conv_if_pkg::window_t win_i,
    input  logic                 pop_i,
    output conv_if_pkg::window_t win_o,
    output logic                 nonempty_o,
    output logic                 credit_o
);
    import conv_if_pkg::*;

    typedef logic [$clog2(IN_CREDITS)-1:0] ptr_t;

    window_t     mem [IN_CREDITS];  // One entry per upstream credit
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    credit_cnt_t count;
    logic        full;
    logic        push;

    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(IN_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == IN_CREDITS);
    assign nonempty_o = (count != '0);
    assign push       = win_valid_i && !full;  // A credited sender never finds it full

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_o <= pop_i;  // The freed entry goes back to upstream as a credit
        end
    end

    // The popped window stays in win_o for the whole computation of both layers
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= win_i;
        end
        if (pop_i) begin
            win_o <= mem[rd_ptr];
        end
    end

endmodule

// ==== rtl/conv_if_pkg.sv ====
// Beat formats and credit constants at the boundaries of the convolution tile
package conv_if_pkg;

    import conv_cfg_pkg::*;

    // One input window, pixels[r][c] is row r and column c of the strip
    typedef struct packed {
        word_t [INPUT_HEIGHT-1:0][KERNEL_WIDTH-1:0] pixels;
    } window_t;

    // Biased sums of one layer, one per output row
    typedef struct packed {
        acc_t [OUT_ROWS-1:0] sums;
    } channel_out_t;

    // Merged output row after ReLU and saturation
    typedef struct packed {
        word_t [OUT_ROWS-1:0] rows;
    } result_t;

    typedef logic [1:0] credit_cnt_t;

    // Upstream starts with one credit per buffer entry
    localparam credit_cnt_t IN_CREDITS  = 2'd2;

    // Results the merge may send before downstream returns a credit
    localparam credit_cnt_t OUT_CREDITS = 2'd2;

endpackage

// ==== rtl/conv_cfg_pkg.sv ====
// Geometry, word types and constant kernel tables of the two-channel convolution tile
package conv_cfg_pkg;

    // Window and kernel geometry
    localparam int INPUT_HEIGHT  = 4;
    localparam int KERNEL_HEIGHT = 3;
    localparam int KERNEL_WIDTH  = 2;
    localparam int OUT_ROWS      = INPUT_HEIGHT - KERNEL_HEIGHT + 1;
    localparam int NUM_STEPS     = KERNEL_HEIGHT * KERNEL_WIDTH + 1; // Kernel taps plus the bias
    localparam int NUM_CHANNELS  = 2;

    localparam int WORD_WIDTH = 16;
    localparam int ACC_WIDTH  = 32;

    typedef logic signed [WORD_WIDTH-1:0]     word_t;  // Pixel, weight and result word
    typedef logic signed [ACC_WIDTH-1:0]      acc_t;   // Accumulator of one output row
    typedef logic [$clog2(NUM_STEPS)-1:0]     step_t;  // ROM address and step counter

    // Largest positive result word
    localparam word_t WORD_MAX = 16'sh7fff;

    // Taps run row by row through the kernel, tap s sits at row s / KERNEL_WIDTH and
    // column s % KERNEL_WIDTH of the kernel
    // The last entry of each channel is its bias
    localparam word_t CONV_WEIGHTS [NUM_CHANNELS][NUM_STEPS] = '{
        '{
            16'sd1,
            16'sd2,
            -16'sd1,
            16'sd3,
            16'sd0,
            16'sd1,
            16'sd5
        },
        '{
            -16'sd2,
            16'sd1,
            16'sd1,
            16'sd0,
            16'sd2,
            -16'sd1,
            -16'sd3
        }
    };

endpackage
